//--- hdl/pmu_cfg_pkg.sv
// --------------------------------------------------
// configuration constants of the performance monitor
// counter slot 15 is reserved and never increments
// --------------------------------------------------
package pmu_cfg_pkg;

    // core and counter geometry
    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned CNT_W           = 64;
    localparam int unsigned NR_COUNTERS     = 16;
    localparam int unsigned IDX_W           = $clog2(NR_COUNTERS);
    localparam int unsigned ADDR_W          = 5;
    // per-event increment reaches NR_COMMIT_PORTS
    localparam int unsigned INC_W           = 2;

    // counter slot map
    localparam int unsigned ICACHE_MISS   = 0;
    localparam int unsigned DCACHE_MISS   = 1;
    localparam int unsigned ITLB_MISS     = 2;
    localparam int unsigned DTLB_MISS     = 3;
    localparam int unsigned LOAD          = 4;
    localparam int unsigned STORE         = 5;
    localparam int unsigned BRANCH_JUMP   = 6;
    localparam int unsigned CALL          = 7;
    localparam int unsigned RET           = 8;
    localparam int unsigned EXCEPTION     = 9;
    localparam int unsigned EXCEPTION_RET = 10;
    localparam int unsigned MIS_PREDICT   = 11;
    localparam int unsigned SB_FULL       = 12;
    localparam int unsigned IF_EMPTY      = 13;
    localparam int unsigned SAMPLE_DROP   = 14;

    // sampling
    localparam int unsigned PERIOD_ADDR    = 16;
    localparam int unsigned PERIOD_W       = 16;
    localparam int unsigned SAMPLE_CREDITS = 4;
    localparam int unsigned CREDIT_W       = $clog2(SAMPLE_CREDITS + 1);

endpackage

//--- hdl/pmu_types_pkg.sv
// --------------------------------------------------
// data types shared by RTL and testbench
// fu_t LOAD/STORE share names with counter slots
// so refer to them by scope when both are imported
// --------------------------------------------------
package pmu_types_pkg;

    // functional unit of a committed instruction
    typedef enum logic [2:0] {
        NONE,
        ALU,
        LOAD,
        STORE,
        CTRL_FLOW
    } fu_t;

    // only the ops the classifier cares about
    typedef enum logic [1:0] {
        ADD,
        JALR,
        OTHER
    } op_t;

    // reduced commit entry, 10 bits
    typedef struct packed {
        fu_t        fu;
        op_t        op;
        logic [4:0] rd;
    } commit_instr_t;

    // single-cycle raw event pulses
    typedef struct packed {
        logic icache_miss;
        logic dcache_miss;
        logic itlb_miss;
        logic dtlb_miss;
        logic exception_valid;
        logic eret;
        logic branch_valid;
        logic branch_mispredict;
        logic sb_full;
        logic if_empty;
    } ext_events_t;

    // one increment per counter slot
    typedef logic [pmu_cfg_pkg::NR_COUNTERS-1:0][pmu_cfg_pkg::INC_W-1:0] event_inc_t;

    // one sample on the trace stream
    typedef struct packed {
        logic [pmu_cfg_pkg::IDX_W-1:0] idx;
        logic [pmu_cfg_pkg::CNT_W-1:0] value;
    } sample_t;

endpackage

//--- hdl/pmu_event_decode.sv
// --------------------------------------------------
// event classification, one register stage
// debug mode masks all events except sample drops
// --------------------------------------------------
module pmu_event_decode (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  logic                                                  debug_mode_i,
    input  pmu_types_pkg::commit_instr_t [pmu_cfg_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
    input  logic [pmu_cfg_pkg::NR_COMMIT_PORTS-1:0]               commit_ack_i,
    input  pmu_types_pkg::ext_events_t                            ext_events_i,
    input  logic                                                  drop_i,
    output pmu_types_pkg::event_inc_t                             inc_o
);
    import pmu_cfg_pkg::*;
    import pmu_types_pkg::*;

    event_inc_t inc_d;

    always_comb begin
        inc_d = '0;
        if (!debug_mode_i) begin
            // commit side, summed over ports
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (commit_ack_i[p]) begin
                    if (commit_instr_i[p].fu == pmu_types_pkg::LOAD)
                        inc_d[pmu_cfg_pkg::LOAD] = inc_d[pmu_cfg_pkg::LOAD] + 1'b1;
                    if (commit_instr_i[p].fu == pmu_types_pkg::STORE)
                        inc_d[pmu_cfg_pkg::STORE] = inc_d[pmu_cfg_pkg::STORE] + 1'b1;
                    if (commit_instr_i[p].fu == CTRL_FLOW)
                        inc_d[BRANCH_JUMP] = inc_d[BRANCH_JUMP] + 1'b1;
                    // call links through x1, jal decodes as ADD
                    if (commit_instr_i[p].fu == CTRL_FLOW && commit_instr_i[p].op == ADD
                        && commit_instr_i[p].rd == 5'd1)
                        inc_d[CALL] = inc_d[CALL] + 1'b1;
                    // return discards the link
                    if (commit_instr_i[p].op == JALR && commit_instr_i[p].rd == 5'd0)
                        inc_d[RET] = inc_d[RET] + 1'b1;
                end
            end
            // raw pulses count one each
            inc_d[ICACHE_MISS]   = INC_W'(ext_events_i.icache_miss);
            inc_d[DCACHE_MISS]   = INC_W'(ext_events_i.dcache_miss);
            inc_d[ITLB_MISS]     = INC_W'(ext_events_i.itlb_miss);
            inc_d[DTLB_MISS]     = INC_W'(ext_events_i.dtlb_miss);
            inc_d[EXCEPTION]     = INC_W'(ext_events_i.exception_valid);
            inc_d[EXCEPTION_RET] = INC_W'(ext_events_i.eret);
            inc_d[MIS_PREDICT]   = INC_W'(ext_events_i.branch_valid
                                          & ext_events_i.branch_mispredict);
            inc_d[SB_FULL]       = INC_W'(ext_events_i.sb_full);
            inc_d[IF_EMPTY]      = INC_W'(ext_events_i.if_empty);
        end
        // drops are sampler bookkeeping, counted in debug too
        inc_d[SAMPLE_DROP] = INC_W'(drop_i);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            inc_o <= '0;
        end else begin
            inc_o <= inc_d;
        end
    end

endmodule

//--- hdl/pmu_counter_bank.sv
// --------------------------------------------------
// counter array plus sample-period register
// CSR write beats a same-cycle increment
// addresses above PERIOD_ADDR read as zero
// --------------------------------------------------
module pmu_counter_bank (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  pmu_types_pkg::event_inc_t           inc_i,
    // CSR side
    input  logic [pmu_cfg_pkg::ADDR_W-1:0]      addr_i,
    input  logic                                we_i,
    input  logic [pmu_cfg_pkg::CNT_W-1:0]       wdata_i,
    output logic [pmu_cfg_pkg::CNT_W-1:0]       rdata_o,
    // sampler side
    input  logic [pmu_cfg_pkg::IDX_W-1:0]       rd_idx_i,
    output logic [pmu_cfg_pkg::CNT_W-1:0]       rd_value_o,
    // to timer
    output logic [pmu_cfg_pkg::PERIOD_W-1:0]    period_o
);
    import pmu_cfg_pkg::*;

    logic [NR_COUNTERS-1:0][CNT_W-1:0] cnt_d, cnt_q;
    logic [PERIOD_W-1:0]               period_d, period_q;
    logic                              is_cnt_addr;
    logic                              is_period_addr;

    assign is_cnt_addr    = addr_i < ADDR_W'(NR_COUNTERS);
    assign is_period_addr = addr_i == ADDR_W'(PERIOD_ADDR);

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        for (int unsigned i = 0; i < NR_COUNTERS; i++) begin
            cnt_d[i] = cnt_q[i] + CNT_W'(inc_i[i]);
        end
        period_d = period_q;
        // write after increment so it wins
        if (we_i && is_cnt_addr)
            cnt_d[addr_i[IDX_W-1:0]] = wdata_i;
        if (we_i && is_period_addr)
            period_d = wdata_i[PERIOD_W-1:0];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q    <= '0;
            period_q <= '0;
        end else begin
            cnt_q    <= cnt_d;
            period_q <= period_d;
        end
    end

    // --------------------------------------------------
    // read ports, both combinational
    // --------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (is_cnt_addr)
            rdata_o = cnt_q[addr_i[IDX_W-1:0]];
        else if (is_period_addr)
            rdata_o = CNT_W'(period_q);
    end

    // sampler reads live values
    assign rd_value_o = cnt_q[rd_idx_i];
    assign period_o   = period_q;

    // nothing is mapped above the period register
    a_no_wr_above_period : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        we_i |-> addr_i <= ADDR_W'(PERIOD_ADDR)
    );

endmodule

//--- hdl/pmu_sample_timer.sv
// --------------------------------------------------
// interval timer, one tick every period cycles
// period 0 disables, any period change restarts
// --------------------------------------------------
module pmu_sample_timer (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic [pmu_cfg_pkg::PERIOD_W-1:0] period_i,
    output logic                             tick_o
);
    import pmu_cfg_pkg::*;

    logic [PERIOD_W-1:0] cnt_q;
    // copy of the period, detects reprogramming
    logic [PERIOD_W-1:0] period_q;
    logic                changed;

    assign changed = period_i != period_q;

    // fire on zero, suppressed while a new period loads
    assign tick_o = !changed && (period_q != '0) && (cnt_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q    <= '0;
            period_q <= '0;
        end else if (changed) begin
            // restart from the new period
            period_q <= period_i;
            cnt_q    <= (period_i == '0) ? '0 : period_i - 1'b1;
        end else if (tick_o) begin
            cnt_q <= period_q - 1'b1;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

//--- hdl/pmu_sample_fsm.sv
// --------------------------------------------------
// sampling pass over all counters on each tick
// one sample per cycle while credits remain
// a tick during a pass is dropped and reported
// --------------------------------------------------
module pmu_sample_fsm (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                tick_i,
    // counter read port
    output logic [pmu_cfg_pkg::IDX_W-1:0]       rd_idx_o,
    input  logic [pmu_cfg_pkg::CNT_W-1:0]       rd_value_i,
    // trace sink
    input  logic                                credit_return_i,
    output logic                                sample_valid_o,
    output pmu_types_pkg::sample_t              sample_o,
    // to decode
    output logic                                drop_o
);
    import pmu_cfg_pkg::*;

    typedef enum logic {
        IDLE,
        SEND
    } state_e;

    state_e              state_d, state_q;
    logic [IDX_W-1:0]    idx_d, idx_q;
    logic [CREDIT_W-1:0] credits_d, credits_q;
    logic                last_idx;

    assign last_idx = idx_q == IDX_W'(NR_COUNTERS - 1);

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign sample_valid_o = (state_q == SEND) && (credits_q != '0);
    assign rd_idx_o       = idx_q;
    assign sample_o.idx   = idx_q;
    assign sample_o.value = rd_value_i;
    // tick while busy
    assign drop_o         = tick_i && (state_q == SEND);

    // --------------------------------------------------
    // pass control
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        case (state_q)
            IDLE: begin
                if (tick_i) begin
                    state_d = SEND;
                    idx_d   = '0;
                end
            end
            SEND: begin
                // advance only on an accepted sample
                if (sample_valid_o) begin
                    idx_d = idx_q + 1'b1;
                    if (last_idx)
                        state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // spend on valid, refill on return
    always_comb begin
        credits_d = credits_q;
        if (sample_valid_o && !credit_return_i)
            credits_d = credits_q - 1'b1;
        else if (!sample_valid_o && credit_return_i)
            credits_d = credits_q + 1'b1;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            idx_q     <= '0;
            credits_q <= CREDIT_W'(SAMPLE_CREDITS);
        end else begin
            state_q   <= state_d;
            idx_q     <= idx_d;
            credits_q <= credits_d;
        end
    end

    // sink returns no more than it was sent
    a_credit_max : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        credits_q <= CREDIT_W'(SAMPLE_CREDITS)
    );

endmodule

//--- hdl/pmu_top.sv
// --------------------------------------------------
// performance monitor top, wiring only
// counter values are read live during a pass
// --------------------------------------------------
module pmu_top (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  logic                                                  debug_mode_i,
    // commit stage
    input  pmu_types_pkg::commit_instr_t [pmu_cfg_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
    input  logic [pmu_cfg_pkg::NR_COMMIT_PORTS-1:0]               commit_ack_i,
    input  pmu_types_pkg::ext_events_t                            ext_events_i,
    // CSR port
    input  logic [pmu_cfg_pkg::ADDR_W-1:0]                        addr_i,
    input  logic                                                  we_i,
    input  logic [pmu_cfg_pkg::CNT_W-1:0]                         wdata_i,
    output logic [pmu_cfg_pkg::CNT_W-1:0]                         rdata_o,
    // trace sink
    output logic                                                  sample_valid_o,
    output pmu_types_pkg::sample_t                                sample_o,
    input  logic                                                  credit_return_i
);
    import pmu_cfg_pkg::*;
    import pmu_types_pkg::*;

    event_inc_t          inc;
    logic [PERIOD_W-1:0] period;
    logic                tick;
    logic                drop;
    logic [IDX_W-1:0]    rd_idx;
    logic [CNT_W-1:0]    rd_value;

    pmu_event_decode i_decode (
        .clk_i, .rst_ni, .debug_mode_i, .commit_instr_i, .commit_ack_i,
        .ext_events_i, .drop_i (drop), .inc_o (inc)
    );

    pmu_counter_bank i_bank (
        .clk_i, .rst_ni, .inc_i (inc), .addr_i, .we_i, .wdata_i, .rdata_o,
        .rd_idx_i (rd_idx), .rd_value_o (rd_value), .period_o (period)
    );

    pmu_sample_timer i_timer (
        .clk_i, .rst_ni, .period_i (period), .tick_o (tick)
    );

    pmu_sample_fsm i_fsm (
        .clk_i, .rst_ni, .tick_i (tick), .rd_idx_o (rd_idx), .rd_value_i (rd_value),
        .credit_return_i, .sample_valid_o, .sample_o, .drop_o (drop)
    );

endmodule

//--- verif/tb_clk_gen.sv
// --------------------------------------------------
// 4 ns clock, reset low for the first two cycles
// --------------------------------------------------
module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

    always #2 clk_o = ~clk_o;

endmodule

//--- verif/tb_pmu.sv
// --------------------------------------------------
// directed tests against a cycle model of the counters
// sink returns credits after a programmable delay
// --------------------------------------------------
module tb_pmu;
    timeunit 1ns;
    timeprecision 100ps;
    import pmu_cfg_pkg::*;
    import pmu_types_pkg::*;

    // cycles per test, summed for the watchdog
    localparam int unsigned RUN_CYCLES = 80 + 300 + 40 + 30 + 250 + 200;

    logic clk_i, rst_ni, debug_mode_i, we_i, credit_return_i, sample_valid_o;
    commit_instr_t [NR_COMMIT_PORTS-1:0] commit_instr_i;
    logic [NR_COMMIT_PORTS-1:0] commit_ack_i;
    ext_events_t ext_events_i;
    logic [ADDR_W-1:0] addr_i;
    logic [CNT_W-1:0] wdata_i, rdata_o;
    sample_t sample_o;

    logic [CNT_W-1:0] mdl [NR_COUNTERS];
    int unsigned mdl_pipe [NR_COUNTERS];
    int unsigned cycle, next_idx, passes, outstanding, credit_delay;
    int unsigned ret_at[$];
    logic sink_on, check_vals;
    logic [31:0] rng;

    tb_clk_gen i_clk (.clk_o (clk_i), .rst_no (rst_ni));

    pmu_top DUT (.*);

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // increments per slot, straight from the classification rules
    function automatic void classify(output int unsigned inc [NR_COUNTERS]);
        foreach (inc[i]) inc[i] = 0;
        if (!debug_mode_i) begin
            for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (commit_ack_i[p]) begin
                    inc[pmu_cfg_pkg::LOAD] += commit_instr_i[p].fu == pmu_types_pkg::LOAD;
                    inc[pmu_cfg_pkg::STORE] += commit_instr_i[p].fu == pmu_types_pkg::STORE;
                    inc[BRANCH_JUMP] += commit_instr_i[p].fu == CTRL_FLOW;
                    inc[CALL] += commit_instr_i[p].fu == CTRL_FLOW
                        && commit_instr_i[p].op == ADD && commit_instr_i[p].rd == 1;
                    inc[RET] += commit_instr_i[p].op == JALR && commit_instr_i[p].rd == 0;
                end
            end
            inc[ICACHE_MISS] = ext_events_i.icache_miss;
            inc[DCACHE_MISS] = ext_events_i.dcache_miss;
            inc[ITLB_MISS] = ext_events_i.itlb_miss;
            inc[DTLB_MISS] = ext_events_i.dtlb_miss;
            inc[EXCEPTION] = ext_events_i.exception_valid;
            inc[EXCEPTION_RET] = ext_events_i.eret;
            inc[MIS_PREDICT] = ext_events_i.branch_valid && ext_events_i.branch_mispredict;
            inc[SB_FULL] = ext_events_i.sb_full;
            inc[IF_EMPTY] = ext_events_i.if_empty;
        end
    endfunction

    // --------------------------------------------------
    // model, sample monitor and credit sink
    // --------------------------------------------------
    always @(posedge clk_i) begin
        int unsigned now_inc [NR_COUNTERS];
        if (!rst_ni) begin
            foreach (mdl[i]) mdl[i] = '0;
            foreach (mdl_pipe[i]) mdl_pipe[i] = 0;
        end else begin
            cycle++;
            if (sample_valid_o) begin
                assert (sample_o.idx == next_idx) else
                    report_fail($sformatf("ERROR sampling: expected idx %0d, actual %0d",
                        next_idx, sample_o.idx));
                assert (!check_vals || sample_o.value == mdl[next_idx]) else
                    report_fail($sformatf("ERROR sampling: expected %0h, actual %0h",
                        mdl[next_idx], sample_o.value));
                if (next_idx == NR_COUNTERS - 1)
                    passes++;
                next_idx = (next_idx + 1) % NR_COUNTERS;
                ret_at.push_back(cycle + credit_delay);
            end
            outstanding = outstanding + sample_valid_o - credit_return_i;
            assert (outstanding <= SAMPLE_CREDITS) else
                report_fail("more samples outstanding than the sink granted credits");
            // registered increments land, then a write overrides
            foreach (mdl[i]) mdl[i] += mdl_pipe[i];
            if (we_i && addr_i < NR_COUNTERS)
                mdl[addr_i] = wdata_i;
            classify(now_inc);
            mdl_pipe = now_inc;
            if (sink_on && ret_at.size() > 0 && ret_at[0] <= cycle) begin
                void'(ret_at.pop_front());
                credit_return_i <= #1 1'b1;
            end else begin
                credit_return_i <= #1 1'b0;
            end
        end
    end

    task automatic csr_write(input int unsigned a, input logic [CNT_W-1:0] d);
        @(posedge clk_i);
        #1 we_i = 1'b1;
        addr_i = a;
        wdata_i = d;
        @(posedge clk_i);
        #1 we_i = 1'b0;
    endtask

    task automatic csr_check(input string name, input int unsigned a,
                             input logic [CNT_W-1:0] exp);
        @(posedge clk_i);
        #1 addr_i = a;
        #1;
        assert (rdata_o == exp) else
            report_fail($sformatf("ERROR %s: expected %0h, actual %0h", name, exp, rdata_o));
    endtask

    task automatic check_all(input string name);
        repeat (3) @(posedge clk_i);
        for (int unsigned i = 0; i < NR_COUNTERS; i++)
            csr_check(name, i, mdl[i]);
    endtask

    task automatic commit(input int unsigned p, input fu_t fu, input op_t op,
                          input logic [4:0] rd);
        commit_instr_i[p].fu = fu;
        commit_instr_i[p].op = op;
        commit_instr_i[p].rd = rd;
        commit_ack_i[p] = 1'b1;
    endtask

    task automatic test_reset_csr();
        for (int unsigned a = 0; a <= PERIOD_ADDR; a++)
            csr_check("reset", a, '0);
        csr_write(3, 64'hdead_beef_0123_4567);
        csr_check("csr_rw", 3, 64'hdead_beef_0123_4567);
        csr_write(15, 64'h5a5a);
        csr_check("csr_rw", 15, 64'h5a5a);
        csr_write(PERIOD_ADDR, 64'h1234);
        csr_check("csr_rw", PERIOD_ADDR, 64'h1234);
        // unmapped space must not alias counters or the period
        for (int unsigned a = PERIOD_ADDR + 1; a < 2 ** ADDR_W; a++)
            csr_check("csr_high", a, '0);
        csr_write(PERIOD_ADDR, 0);
    endtask

    task automatic test_raw_events();
        for (int n = 0; n < 200; n++) begin
            @(posedge clk_i);
            rng = xorshift(rng);
            #1 ext_events_i = rng[9:0];
            debug_mode_i = n >= 150 && n < 180;
        end
        @(posedge clk_i);
        #1 ext_events_i = '0;
        debug_mode_i = 1'b0;
        check_all("raw_events");
    endtask

    task automatic test_commit();
        logic [CNT_W-1:0] loads;
        loads = mdl[pmu_cfg_pkg::LOAD];
        @(posedge clk_i);
        #1 commit(0, pmu_types_pkg::LOAD, OTHER, 5);
        commit(1, pmu_types_pkg::LOAD, OTHER, 6);
        @(posedge clk_i);
        #1 commit(0, pmu_types_pkg::STORE, OTHER, 0);
        commit(1, CTRL_FLOW, ADD, 1);
        @(posedge clk_i);
        #1 commit(0, CTRL_FLOW, JALR, 0);
        commit(1, pmu_types_pkg::STORE, OTHER, 0);
        commit_ack_i[1] = 1'b0;
        @(posedge clk_i);
        #1 commit_ack_i = '0;
        check_all("commit");
        csr_check("commit_dual", pmu_cfg_pkg::LOAD, loads + 2);
    endtask

    task automatic test_write_priority();
        @(posedge clk_i);
        #1 ext_events_i.dcache_miss = 1'b1;
        @(posedge clk_i);
        #1 ext_events_i = '0;
        we_i = 1'b1;
        addr_i = DCACHE_MISS;
        wdata_i = 64'h77;
        @(posedge clk_i);
        #1 we_i = 1'b0;
        check_all("write_priority");
        csr_check("write_priority", DCACHE_MISS, 64'h77);
    endtask

    task automatic test_sampling();
        credit_delay = 3;
        csr_write(PERIOD_ADDR, 40);
        wait (passes >= 2);
        csr_write(PERIOD_ADDR, 0);
        wait (outstanding == 0);
        assert (next_idx == 0) else report_fail("sampling pass left incomplete");
    endtask

    task automatic test_drops();
        localparam int unsigned P = 10;
        localparam int unsigned K = 5;
        int unsigned start_passes;
        start_passes = passes;
        check_vals = 1'b0;
        sink_on = 1'b0;
        csr_write(PERIOD_ADDR, P);
        // window ends mid-period so exactly K ticks fall in it
        repeat (K * P + P / 2) @(posedge clk_i);
        csr_write(PERIOD_ADDR, 0);
        sink_on = 1'b1;
        wait (passes == start_passes + 1 && outstanding == 0);
        csr_check("drops", SAMPLE_DROP, K - 1);
    endtask

    initial begin
        rng = 32'd57;
        cycle = 0;
        next_idx = 0;
        passes = 0;
        outstanding = 0;
        credit_delay = 2;
        sink_on = 1'b1;
        check_vals = 1'b1;
        debug_mode_i = 1'b0;
        commit_instr_i = '0;
        commit_ack_i = '0;
        ext_events_i = '0;
        addr_i = '0;
        we_i = 1'b0;
        wdata_i = '0;
        credit_return_i <= 1'b0;
        wait (rst_ni);
        test_reset_csr();
        test_raw_events();
        test_commit();
        test_write_priority();
        test_sampling();
        test_drops();
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #(RUN_CYCLES * 4 * 2);
        report_fail("timeout, the run did not finish in time");
    end

endmodule

//--- vlog.f
hdl/pmu_cfg_pkg.sv
hdl/pmu_types_pkg.sv
hdl/pmu_event_decode.sv
hdl/pmu_counter_bank.sv
hdl/pmu_sample_timer.sv
hdl/pmu_sample_fsm.sv
hdl/pmu_top.sv
verif/tb_clk_gen.sv
verif/tb_pmu.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the PMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_pmu -f vlog.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_pmu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
